//--- dcache_pkg.sv
package dcache_pkg;

    // Cache geometry: 512 sets, 2 ways, 64-byte lines of eight 64-bit banks
    localparam int NUM_WAYS     = 2;
    localparam int NUM_BANKS    = 8;
    localparam int SET_WIDTH    = 9;
    localparam int TAG_WIDTH    = 17;
    localparam int BANK_WIDTH   = 3;
    localparam int OFFSET_WIDTH = 3;
    localparam int ADDR_WIDTH   = TAG_WIDTH + SET_WIDTH + BANK_WIDTH + OFFSET_WIDTH;
    localparam int NUM_SETS     = 1 << SET_WIDTH;

    // Decoded view of a byte address
    typedef struct packed {
        logic [TAG_WIDTH-1:0]    tag;
        logic [SET_WIDTH-1:0]    set;
        logic [BANK_WIDTH-1:0]   bank;
        logic [OFFSET_WIDTH-1:0] offset;
    } addr_fields_t;

    // Same 32-bit word, seen flat or split into cache fields
    typedef union packed {
        logic [ADDR_WIDTH-1:0] raw;
        addr_fields_t          fields;
    } dcache_addr_u;

    // One way of one set in the tag array
    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    // One-hot way select
    typedef logic [NUM_WAYS-1:0] way_oh_t;

endpackage

//--- tbus_pkg.sv
package tbus_pkg;

    localparam int TBUS_DATA_WIDTH = 64;

    typedef enum logic [1:0] {
        TBUS_READ  = 2'd0,
        TBUS_WRITE = 2'd1
    } tbus_op_e;

    // Request beat on the trinity bus
    typedef struct packed {
        tbus_op_e                   op;
        dcache_pkg::dcache_addr_u   index;
        logic [TBUS_DATA_WIDTH-1:0] write_data;
        // One bit per data bit, set means written
        logic [TBUS_DATA_WIDTH-1:0] write_mask;
    } tbus_req_t;

    // Completion payload, only meaningful for reads
    typedef struct packed {
        logic [TBUS_DATA_WIDTH-1:0] read_data;
    } tbus_resp_t;

endpackage

//--- dcache_tagarray.sv
`timescale 1ns/100ps

module dcache_tagarray (
    input  logic                                clock,
    input  logic                                reset_n,
    input  logic                                ce,
    input  logic [dcache_pkg::SET_WIDTH-1:0]    set_addr,
    input  logic [dcache_pkg::TAG_WIDTH-1:0]    lookup_tag,
    input  logic                                we,
    input  dcache_pkg::way_oh_t                 write_way,
    input  dcache_pkg::tag_entry_t              write_entry,
    output logic                                hit,
    output dcache_pkg::way_oh_t                 hit_way,
    output dcache_pkg::way_oh_t                 victim_way,
    output dcache_pkg::tag_entry_t              victim_entry
);

    logic [dcache_pkg::NUM_SETS-1:0][dcache_pkg::NUM_WAYS-1:0] valid_q;
    logic [dcache_pkg::NUM_SETS-1:0]                           victim_q;
    logic [dcache_pkg::NUM_WAYS-1:0]  dirty_mem [dcache_pkg::NUM_SETS];
    logic [dcache_pkg::TAG_WIDTH-1:0] tag_mem [dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS];

    dcache_pkg::tag_entry_t [dcache_pkg::NUM_WAYS-1:0] rd_entry_q;
    logic                                              rd_victim_q;
    logic                                              install;

    // A write installs a new line when the target way held another tag
    always_comb begin
        install = 1'b0;
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            if (write_way[w] && (!valid_q[set_addr][w] ||
                                 tag_mem[set_addr][w] != write_entry.tag)) begin
                install = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid_q     <= '0;
            victim_q    <= '0;
            rd_entry_q  <= '0;
            rd_victim_q <= 1'b0;
        end else begin
            if (we) begin
                for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
                    if (write_way[w]) begin
                        valid_q[set_addr][w] <= write_entry.valid;
                    end
                end
                // Round robin advances only on a fresh install
                if (install) begin
                    victim_q[set_addr] <= ~victim_q[set_addr];
                end
            end
            if (ce) begin
                for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
                    rd_entry_q[w].valid <= valid_q[set_addr][w];
                    rd_entry_q[w].dirty <= dirty_mem[set_addr][w];
                    rd_entry_q[w].tag   <= tag_mem[set_addr][w];
                end
                rd_victim_q <= victim_q[set_addr];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (we) begin
            for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
                if (write_way[w]) begin
                    tag_mem[set_addr][w]   <= write_entry.tag;
                    dirty_mem[set_addr][w] <= write_entry.dirty;
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            hit_way[w] = rd_entry_q[w].valid && (rd_entry_q[w].tag == lookup_tag);
        end
    end

    assign hit          = |hit_way;
    assign victim_way   = dcache_pkg::way_oh_t'(1) << rd_victim_q;
    assign victim_entry = rd_entry_q[rd_victim_q];

    // No tag is ever installed twice in one set
    assert property (@(posedge clock) disable iff (!reset_n) $onehot0(hit_way));

endmodule

//--- dcache_dataarray.sv
`timescale 1ns/100ps

module dcache_dataarray (
    input  logic                                  clock,
    input  logic                                  ce,
    input  dcache_pkg::way_oh_t                   way,
    input  logic [dcache_pkg::SET_WIDTH-1:0]      set_addr,
    input  logic [dcache_pkg::BANK_WIDTH-1:0]     bank,
    input  logic                                  we,
    input  logic [tbus_pkg::TBUS_DATA_WIDTH-1:0]  write_data,
    input  logic [tbus_pkg::TBUS_DATA_WIDTH-1:0]  write_mask,
    output logic [tbus_pkg::TBUS_DATA_WIDTH-1:0]  read_data
);

    localparam int NUM_WORDS = dcache_pkg::NUM_WAYS * dcache_pkg::NUM_BANKS;

    // One storage column per way and bank
    logic [tbus_pkg::TBUS_DATA_WIDTH-1:0] word_mem [NUM_WORDS][dcache_pkg::NUM_SETS];
    logic [NUM_WORDS-1:0]                 word_en;
    logic [tbus_pkg::TBUS_DATA_WIDTH-1:0] rd_mux;

    always_comb begin
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            for (int b = 0; b < dcache_pkg::NUM_BANKS; b++) begin
                word_en[w*dcache_pkg::NUM_BANKS + b] =
                    way[w] && (bank == dcache_pkg::BANK_WIDTH'(b));
            end
        end
    end

    // Way is one-hot so at most one column contributes
    always_comb begin
        rd_mux = '0;
        for (int i = 0; i < NUM_WORDS; i++) begin
            if (word_en[i]) begin
                rd_mux = rd_mux | word_mem[i][set_addr];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ce) begin
            for (int i = 0; i < NUM_WORDS; i++) begin
                if (we && word_en[i]) begin
                    word_mem[i][set_addr] <= (word_mem[i][set_addr] & ~write_mask) |
                                             (write_data & write_mask);
                end
            end
            // Read before write, old word comes back
            read_data <= rd_mux;
        end
    end

    // Controller never writes without enabling the array
    assert property (@(posedge clock) we |-> ce);

endmodule

//--- dcache.sv
`timescale 1ns/100ps

module dcache (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 tbus_index_valid,
    output logic                 tbus_index_ready,
    input  tbus_pkg::tbus_req_t  tbus_req,
    output logic                 tbus_operation_done,
    output tbus_pkg::tbus_resp_t tbus_resp,
    output logic                 dcache2arb_tbus_index_valid,
    input  logic                 dcache2arb_tbus_index_ready,
    output tbus_pkg::tbus_req_t  dcache2arb_tbus_req,
    input  logic                 dcache2arb_tbus_operation_done,
    input  tbus_pkg::tbus_resp_t dcache2arb_tbus_resp
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ_TAG,
        S_RW_DATA,
        S_WRITEBACK,
        S_READ_MEM,
        S_REFILL,
        S_RESPOND
    } state_e;

    state_e                                state_q;
    logic [dcache_pkg::BANK_WIDTH-1:0]     beat_q;
    logic                                  issued_q;
    logic                                  wb_fetch_q;
    dcache_pkg::way_oh_t                   way_q;
    tbus_pkg::tbus_req_t                   req_q;
    logic [dcache_pkg::TAG_WIDTH-1:0]      victim_tag_q;
    logic [tbus_pkg::TBUS_DATA_WIDTH-1:0]  fill_q;

    logic                                  accept;
    logic                                  is_write;
    logic                                  last_beat;

    logic                                  tag_ce;
    logic [dcache_pkg::SET_WIDTH-1:0]      tag_set;
    logic                                  tag_we;
    dcache_pkg::tag_entry_t                tag_wentry;
    logic                                  hit;
    dcache_pkg::way_oh_t                   hit_way;
    dcache_pkg::way_oh_t                   victim_way;
    dcache_pkg::tag_entry_t                victim_entry;

    logic                                  data_ce;
    logic                                  data_we;
    logic [dcache_pkg::BANK_WIDTH-1:0]     data_bank;
    logic [tbus_pkg::TBUS_DATA_WIDTH-1:0]  data_wdata;
    logic [tbus_pkg::TBUS_DATA_WIDTH-1:0]  data_wmask;
    logic [tbus_pkg::TBUS_DATA_WIDTH-1:0]  data_rd;

    assign tbus_index_ready = (state_q == S_IDLE);
    assign accept           = tbus_index_valid && tbus_index_ready;
    assign is_write         = (req_q.op == tbus_pkg::TBUS_WRITE);
    assign last_beat        = (beat_q == '1);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state_q    <= S_IDLE;
            beat_q     <= '0;
            issued_q   <= 1'b0;
            wb_fetch_q <= 1'b0;
            way_q      <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (accept) begin
                        state_q <= S_READ_TAG;
                    end
                end
                S_READ_TAG: begin
                    beat_q <= '0;
                    if (hit) begin
                        way_q   <= hit_way;
                        state_q <= S_RW_DATA;
                    end else begin
                        way_q   <= victim_way;
                        state_q <= (victim_entry.valid && victim_entry.dirty) ?
                                   S_WRITEBACK : S_READ_MEM;
                    end
                end
                S_RW_DATA: state_q <= S_RESPOND;
                S_WRITEBACK: begin
                    // Fetch word, offer it downstream, then wait for completion
                    if (!wb_fetch_q) begin
                        wb_fetch_q <= 1'b1;
                    end else if (!issued_q) begin
                        issued_q <= dcache2arb_tbus_index_ready;
                    end else if (dcache2arb_tbus_operation_done) begin
                        issued_q   <= 1'b0;
                        wb_fetch_q <= 1'b0;
                        beat_q     <= beat_q + 1'b1;
                        if (last_beat) begin
                            state_q <= S_READ_MEM;
                        end
                    end
                end
                S_READ_MEM: begin
                    if (!issued_q) begin
                        issued_q <= dcache2arb_tbus_index_ready;
                    end else if (dcache2arb_tbus_operation_done) begin
                        issued_q <= 1'b0;
                        state_q  <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    beat_q  <= beat_q + 1'b1;
                    // Replay the access as a hit once the last word is in
                    state_q <= last_beat ? S_RW_DATA : S_READ_MEM;
                end
                S_RESPOND: state_q <= S_IDLE;
                default:   state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_q <= tbus_req;
        end
        if (state_q == S_READ_TAG) begin
            victim_tag_q <= victim_entry.tag;
        end
        if (state_q == S_READ_MEM && issued_q && dcache2arb_tbus_operation_done) begin
            fill_q <= dcache2arb_tbus_resp.read_data;
        end
    end

    // Tag lookup uses the incoming set while idle
    assign tag_ce  = accept;
    assign tag_set = (state_q == S_IDLE) ? tbus_req.index.fields.set : req_q.index.fields.set;
    assign tag_we  = (state_q == S_REFILL && last_beat) || (state_q == S_RW_DATA && is_write);

    always_comb begin
        tag_wentry.valid = 1'b1;
        tag_wentry.dirty = (state_q == S_RW_DATA);
        tag_wentry.tag   = req_q.index.fields.tag;
    end

    always_comb begin
        data_ce    = 1'b0;
        data_we    = 1'b0;
        data_bank  = beat_q;
        data_wdata = fill_q;
        data_wmask = '1;
        case (state_q)
            S_RW_DATA: begin
                data_ce    = 1'b1;
                data_we    = is_write;
                data_bank  = req_q.index.fields.bank;
                data_wdata = req_q.write_data;
                data_wmask = req_q.write_mask;
            end
            S_WRITEBACK: data_ce = !wb_fetch_q;
            S_REFILL: begin
                data_ce = 1'b1;
                data_we = 1'b1;
            end
            default: data_ce = 1'b0;
        endcase
    end

    assign dcache2arb_tbus_index_valid = !issued_q &&
        (state_q == S_READ_MEM || (state_q == S_WRITEBACK && wb_fetch_q));

    always_comb begin
        dcache2arb_tbus_req                   = '0;
        dcache2arb_tbus_req.index.fields.set  = req_q.index.fields.set;
        dcache2arb_tbus_req.index.fields.bank = beat_q;
        if (state_q == S_WRITEBACK) begin
            dcache2arb_tbus_req.op               = tbus_pkg::TBUS_WRITE;
            dcache2arb_tbus_req.index.fields.tag = victim_tag_q;
            dcache2arb_tbus_req.write_data       = data_rd;
            dcache2arb_tbus_req.write_mask       = '1;
        end else begin
            dcache2arb_tbus_req.op               = tbus_pkg::TBUS_READ;
            dcache2arb_tbus_req.index.fields.tag = req_q.index.fields.tag;
        end
    end

    assign tbus_operation_done = (state_q == S_RESPOND);
    assign tbus_resp.read_data = (tbus_operation_done && !is_write) ? data_rd : '0;

    dcache_tagarray tagarray_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .ce           (tag_ce),
        .set_addr     (tag_set),
        .lookup_tag   (req_q.index.fields.tag),
        .we           (tag_we),
        .write_way    (way_q),
        .write_entry  (tag_wentry),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_entry (victim_entry)
    );

    dcache_dataarray dataarray_i (
        .clock      (clock),
        .ce         (data_ce),
        .way        (way_q),
        .set_addr   (req_q.index.fields.set),
        .bank       (data_bank),
        .we         (data_we),
        .write_data (data_wdata),
        .write_mask (data_wmask),
        .read_data  (data_rd)
    );

    // Downstream request holds until the memory side takes it
    assert property (@(posedge clock) disable iff (!reset_n)
        dcache2arb_tbus_index_valid && !dcache2arb_tbus_index_ready |=>
            dcache2arb_tbus_index_valid && $stable(dcache2arb_tbus_req));

    // Idle is only re-entered right after a completion
    assert property (@(posedge clock) disable iff (!reset_n)
        $rose(tbus_index_ready) |-> $past(tbus_operation_done));

endmodule

//--- tb_dcache_mem.sv
`timescale 1ns/100ps

module tb_dcache_mem (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 index_valid,
    output logic                 index_ready,
    input  tbus_pkg::tbus_req_t  req,
    output logic                 operation_done,
    output tbus_pkg::tbus_resp_t resp
);

    // Only written words are stored, the rest read as a fill pattern
    logic [63:0]         store [logic [31:0]];
    tbus_pkg::tbus_req_t write_log [$];
    logic [31:0]         read_log [$];

    function automatic logic [63:0] fill_word(input logic [31:0] addr);
        logic [31:0] word;
        word = {addr[31:3], 3'b000};
        return {word ^ 32'hc3a5_5a3c, (~word) + 32'h1357_9bdf};
    endfunction

    function automatic logic [63:0] read_word(input logic [31:0] word);
        if (store.exists(word)) begin
            return store[word];
        end
        return fill_word(word);
    endfunction

    initial begin
        tbus_pkg::tbus_req_t pending;
        logic                busy;
        int unsigned         delay;
        logic [31:0]         word;
        pending        = '0;
        busy           = 1'b0;
        delay          = 0;
        index_ready    = 1'b0;
        operation_done = 1'b0;
        resp           = '0;
        forever begin
            @(negedge clock);
            operation_done = 1'b0;
            resp           = '0;
            if (!reset_n) begin
                index_ready = 1'b0;
                busy        = 1'b0;
            end else if (busy) begin
                if (delay != 0) begin
                    delay--;
                end else begin
                    word           = {pending.index.raw[31:3], 3'b000};
                    busy           = 1'b0;
                    operation_done = 1'b1;
                    if (pending.op == tbus_pkg::TBUS_WRITE) begin
                        store[word] = (read_word(word) & ~pending.write_mask) |
                                      (pending.write_data & pending.write_mask);
                        write_log.push_back(pending);
                    end else begin
                        resp.read_data = read_word(word);
                        read_log.push_back(word);
                    end
                end
            end else begin
                // Back-pressure about one cycle in four
                index_ready = ($urandom_range(3) != 0);
                if (index_valid && index_ready) begin
                    pending = req;
                    busy    = 1'b1;
                    // Completion 1 to 4 cycles after the accept edge
                    delay   = $urandom_range(3);
                end
            end
        end
    end

endmodule

//--- tb_dcache.sv
`timescale 1ns/100ps

module tb_dcache;

    localparam int CYCLES_PER_REQUEST = 200;
    localparam int CYCLE_MARGIN       = 100;
    localparam int RANDOM_REQUESTS    = 200;

    localparam logic [31:0] FRESH_WORD = {17'h00123, 9'd40, 3'd2, 3'd0};
    localparam logic [31:0] MERGE_WORD = {17'h00123, 9'd40, 3'd5, 3'd0};
    localparam logic [31:0] EVICT_A    = {17'h00a01, 9'd200, 3'd1, 3'd0};
    localparam logic [31:0] EVICT_B    = {17'h00b02, 9'd200, 3'd6, 3'd0};
    localparam logic [31:0] EVICT_C    = {17'h00c03, 9'd200, 3'd4, 3'd0};

    logic                 clock = 1'b0;
    logic                 reset_n;
    logic                 tbus_index_valid;
    logic                 tbus_index_ready;
    tbus_pkg::tbus_req_t  tbus_req;
    logic                 tbus_operation_done;
    tbus_pkg::tbus_resp_t tbus_resp;
    logic                 mem_valid;
    logic                 mem_ready;
    tbus_pkg::tbus_req_t  mem_req;
    logic                 mem_done;
    tbus_pkg::tbus_resp_t mem_resp;

    // Upstream view of memory, written words only
    logic [63:0]          golden [logic [31:0]];
    tbus_pkg::tbus_resp_t expected_resp [int];
    int                   request_count = 0;
    int                   done_count    = 0;
    int                   cycle_count   = 0;
    int                   check_count   = 0;
    int                   error_count   = 0;
    int                   resp_checks   = 0;
    int                   resp_errors   = 0;

    always #4 clock = ~clock;

    dcache dut_i (
        .clock                          (clock),
        .reset_n                        (reset_n),
        .tbus_index_valid               (tbus_index_valid),
        .tbus_index_ready               (tbus_index_ready),
        .tbus_req                       (tbus_req),
        .tbus_operation_done            (tbus_operation_done),
        .tbus_resp                      (tbus_resp),
        .dcache2arb_tbus_index_valid    (mem_valid),
        .dcache2arb_tbus_index_ready    (mem_ready),
        .dcache2arb_tbus_req            (mem_req),
        .dcache2arb_tbus_operation_done (mem_done),
        .dcache2arb_tbus_resp           (mem_resp)
    );

    tb_dcache_mem mem_i (
        .clock          (clock),
        .reset_n        (reset_n),
        .index_valid    (mem_valid),
        .index_ready    (mem_ready),
        .req            (mem_req),
        .operation_done (mem_done),
        .resp           (mem_resp)
    );

    function automatic logic [63:0] fill_word(input logic [31:0] addr);
        logic [31:0] word;
        word = {addr[31:3], 3'b000};
        return {word ^ 32'hc3a5_5a3c, (~word) + 32'h1357_9bdf};
    endfunction

    function automatic logic [63:0] line_word(input logic [31:0] addr);
        logic [31:0] word;
        word = {addr[31:3], 3'b000};
        if (golden.exists(word)) begin
            return golden[word];
        end
        return fill_word(word);
    endfunction

    // Expected response, and the golden update for writes
    function automatic tbus_pkg::tbus_resp_t ref_access(input tbus_pkg::tbus_req_t req);
        tbus_pkg::tbus_resp_t resp;
        logic [31:0]          word;
        resp = '0;
        word = {req.index.raw[31:3], 3'b000};
        if (req.op == tbus_pkg::TBUS_WRITE) begin
            golden[word] = (line_word(word) & ~req.write_mask) |
                           (req.write_data & req.write_mask);
        end else begin
            resp.read_data = line_word(word);
        end
        return resp;
    endfunction

    function automatic int total_errors();
        return error_count + resp_errors;
    endfunction

    task automatic check_resp(input tbus_pkg::tbus_resp_t got, input tbus_pkg::tbus_resp_t exp);
        resp_checks++;
        if (got !== exp) begin
            resp_errors++;
            $display("[ERROR] tbus_resp.read_data got %h expected %h",
                     got.read_data, exp.read_data);
        end
    endtask

    task automatic check_mem_write(input tbus_pkg::tbus_req_t got,
                                   input tbus_pkg::tbus_req_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] dcache2arb_tbus_req got %h expected %h", got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (total_errors() == errors_before) begin
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: failed with %0d errors", name, total_errors() - errors_before);
        end
    endtask

    // One request, returns the edges from accept to the edge that samples done
    task automatic issue(input tbus_pkg::tbus_op_e op, input logic [31:0] addr,
                         input logic [63:0] data, input logic [63:0] mask,
                         output int latency);
        tbus_pkg::tbus_req_t req;
        req.op         = op;
        req.index.raw  = addr;
        req.write_data = data;
        req.write_mask = mask;
        while (!tbus_index_ready) begin
            @(negedge clock);
        end
        expected_resp[request_count] = ref_access(req);
        request_count++;
        tbus_req         = req;
        tbus_index_valid = 1'b1;
        @(negedge clock);
        tbus_index_valid = 1'b0;
        latency          = 1;
        while (!tbus_operation_done) begin
            @(negedge clock);
            latency++;
        end
        // Let the compare process see this done pulse
        @(negedge clock);
    endtask

    // Every done pulse against the response queued at issue
    always @(negedge clock) begin
        if (reset_n && tbus_operation_done) begin
            if (done_count >= request_count) begin
                resp_errors++;
                $display("Done pulse seen with no request outstanding");
            end else begin
                check_resp(tbus_resp, expected_resp[done_count]);
            end
            done_count++;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > CYCLES_PER_REQUEST * request_count + CYCLE_MARGIN) begin
            $display("Timeout after %0d cycles with %0d requests issued",
                     cycle_count, request_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        int                  errors_before;
        int                  latency;
        int                  log_before;
        logic [31:0]         addr;
        logic [63:0]         data;
        logic [63:0]         mask;
        tbus_pkg::tbus_op_e  op;
        tbus_pkg::tbus_req_t exp_write;
        void'($urandom(54));
        reset_n          = 1'b0;
        tbus_index_valid = 1'b0;
        tbus_req         = '0;
        repeat (3) @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);

        errors_before = total_errors();
        check_flag("tbus_index_ready", tbus_index_ready, 1'b1);
        check_flag("tbus_operation_done", tbus_operation_done, 1'b0);
        check_flag("dcache2arb_tbus_index_valid", mem_valid, 1'b0);
        report_test("reset state", errors_before);

        // Fresh line, filled by eight reads in bank order
        errors_before = total_errors();
        log_before    = mem_i.read_log.size();
        issue(tbus_pkg::TBUS_READ, FRESH_WORD, '0, '0, latency);
        check_word("downstream read count", 32'(mem_i.read_log.size() - log_before), 32'd8);
        for (int i = 0; i < 8; i++) begin
            if (log_before + i < mem_i.read_log.size()) begin
                check_word("downstream read address", mem_i.read_log[log_before + i],
                           {FRESH_WORD[31:6], 3'(i), 3'b000});
            end
        end
        report_test("read miss refill", errors_before);

        errors_before = total_errors();
        issue(tbus_pkg::TBUS_WRITE, MERGE_WORD, 64'h0123_4567_89ab_cdef,
              64'h00ff_ff00_f0f0_0ff0, latency);
        issue(tbus_pkg::TBUS_READ, MERGE_WORD, '0, '0, latency);
        check_word("read hit latency", 32'(latency), 32'd3);
        report_test("masked write merge", errors_before);

        // Dirty line in way 0 is the victim on the third miss
        errors_before = total_errors();
        issue(tbus_pkg::TBUS_WRITE, EVICT_A, 64'hfeed_face_cafe_f00d, '1, latency);
        issue(tbus_pkg::TBUS_READ, EVICT_B, '0, '0, latency);
        log_before = mem_i.write_log.size();
        issue(tbus_pkg::TBUS_READ, EVICT_C, '0, '0, latency);
        check_word("downstream write count", 32'(mem_i.write_log.size() - log_before), 32'd8);
        for (int i = 0; i < 8; i++) begin
            exp_write.op         = tbus_pkg::TBUS_WRITE;
            exp_write.index.raw  = {EVICT_A[31:6], 3'(i), 3'b000};
            exp_write.write_data = line_word(exp_write.index.raw);
            exp_write.write_mask = '1;
            if (log_before + i < mem_i.write_log.size()) begin
                check_mem_write(mem_i.write_log[log_before + i], exp_write);
            end
        end
        report_test("dirty writeback", errors_before);

        errors_before = total_errors();
        for (int n = 0; n < RANDOM_REQUESTS; n++) begin
            addr = {17'(32'h1000 + $urandom_range(3)), 9'(32'd300 + $urandom_range(2)),
                    3'($urandom_range(7)), 3'b000};
            op   = ($urandom_range(1) == 0) ? tbus_pkg::TBUS_READ : tbus_pkg::TBUS_WRITE;
            data = {$urandom, $urandom};
            mask = {$urandom, $urandom};
            issue(op, addr, data, mask, latency);
        end
        report_test("random traffic", errors_before);

        if (done_count != request_count) begin
            error_count++;
            $display("Only %0d of %0d requests completed", done_count, request_count);
        end
        $display("Checks: %0d, errors: %0d", check_count + resp_checks, total_errors());
        if (total_errors() == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- dcache.f
dcache_pkg.sv
tbus_pkg.sv
dcache_tagarray.sv
dcache_dataarray.sv
dcache.sv
tb_dcache_mem.sv
tb_dcache.sv

//--- run.sh
#!/bin/sh
# Build the dcache testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_dcache -f dcache.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_dcache)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
